// File: hdl/mem_pkg.sv
package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_W = 19;             // Word address, bits 19:1.
    localparam int DATA_W = 16;
    localparam int BSEL_W = 2;              // Bit 0 low byte, bit 1 high byte.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prefetch queue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int QUEUE_DEPTH = 4;         // Power of two, pointers wrap.
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int WAIT_STATES = 2;
    localparam int WAIT_CNT_W = $clog2(WAIT_STATES + 1);
    localparam int SRAM_WORDS = 1024;
    // Higher word address bits alias onto the array.
    localparam int SRAM_AW = $clog2(SRAM_WORDS);

endpackage

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // Instruction bus
    input  logic [ADDR_W-1:0] instr_addr,
    input  logic              instr_access,
    output logic [DATA_W-1:0] instr_rdata,
    output logic              instr_ack,
    // Data bus
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    input  logic              data_access,
    input  logic              data_wr_en,
    input  logic [BSEL_W-1:0] data_bytesel,
    output logic [DATA_W-1:0] data_rdata,
    output logic              data_ack,
    // Memory bus
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    output logic              mem_access,
    output logic              mem_wr_en,
    output logic [BSEL_W-1:0] mem_bytesel,
    input  logic [DATA_W-1:0] mem_rdata,
    input  logic              mem_ack
);

    logic instr_grant;
    logic data_grant;
    logic instr_will_grant;
    logic data_will_grant;
    logic route_data;

    // Data wins a tie so the executing instruction can finish.
    assign data_will_grant  = data_access & ~instr_grant & ~data_grant;
    assign instr_will_grant = instr_access & ~data_access & ~data_grant & ~instr_grant;

    assign route_data = data_grant | data_will_grant;

    assign mem_addr    = route_data ? data_addr : instr_addr;
    assign mem_wdata   = data_wdata;
    assign mem_access  = route_data ? data_access : instr_access;
    assign mem_wr_en   = route_data ? data_wr_en : 1'b0;        // Fetches only read.
    assign mem_bytesel = route_data ? data_bytesel : {BSEL_W{1'b1}};

    assign instr_rdata = mem_rdata;
    assign data_rdata  = mem_rdata;
    assign instr_ack   = instr_grant & mem_ack;
    assign data_ack    = data_grant & mem_ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_grant <= 1'b0;
            data_grant  <= 1'b0;
        end else begin
            if (data_ack)
                data_grant <= 1'b0;
            else if (data_will_grant)
                data_grant <= 1'b1;

            if (instr_ack)
                instr_grant <= 1'b0;
            else if (instr_will_grant)
                instr_grant <= 1'b1;
        end
    end

endmodule

// File: hdl/instr_prefetch.sv
`timescale 1ns/1ps

module instr_prefetch import mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic [ADDR_W-1:0] flush_addr,
    input  logic              pop,
    output logic [DATA_W-1:0] instr_word,
    output logic              instr_valid,
    // Instruction bus
    output logic [ADDR_W-1:0] instr_addr,
    output logic              instr_access,
    input  logic [DATA_W-1:0] instr_rdata,
    input  logic              instr_ack
);

    logic [DATA_W-1:0]      queue [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic [QUEUE_CNT_W-1:0] count_next;
    logic [ADDR_W-1:0]      next_addr;
    logic                   stale;
    logic                   busy;
    logic                   push;
    logic                   pop_ok;
    logic                   issue;

    assign busy   = instr_access & ~instr_ack;          // Fetch still open after this edge.
    assign push   = instr_ack & ~stale & ~flush;
    assign pop_ok = pop & instr_valid & ~flush;

    assign instr_valid = count != '0;
    assign instr_word  = queue[rd_ptr];

    always_comb begin
        if (flush)
            count_next = '0;
        else if (push & ~pop_ok)
            count_next = count + 1'b1;
        else if (pop_ok & ~push)
            count_next = count - 1'b1;
        else
            count_next = count;
    end

    // Only one fetch in flight, and never more than the queue can take.
    assign issue = ~busy & (count_next < QUEUE_CNT_W'(QUEUE_DEPTH));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch and queue control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr       <= '0;
            wr_ptr       <= '0;
            count        <= '0;
            next_addr    <= '0;
            instr_addr   <= '0;
            instr_access <= 1'b0;
            stale        <= 1'b0;
        end else begin
            count        <= count_next;
            instr_access <= busy | issue;

            if (flush) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                if (push)
                    wr_ptr <= wr_ptr + 1'b1;
                if (pop_ok)
                    rd_ptr <= rd_ptr + 1'b1;
            end

            // A fetch cut off by flush returns a word from the old stream.
            if (flush & busy)
                stale <= 1'b1;
            else if (instr_ack)
                stale <= 1'b0;

            if (issue) begin
                if (flush) begin
                    instr_addr <= flush_addr;
                    next_addr  <= flush_addr + 1'b1;
                end else begin
                    instr_addr <= next_addr;
                    next_addr  <= next_addr + 1'b1;
                end
            end else if (flush) begin
                next_addr <= flush_addr;    // Held until the open fetch ends.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            queue[wr_ptr] <= instr_rdata;
    end

endmodule

// File: hdl/sram_ctrl.sv
`timescale 1ns/1ps

module sram_ctrl import mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_wdata,
    input  logic              mem_access,
    input  logic              mem_wr_en,
    input  logic [BSEL_W-1:0] mem_bytesel,
    output logic [DATA_W-1:0] mem_rdata,
    output logic              mem_ack
);

    logic [DATA_W-1:0]     mem_array [SRAM_WORDS];
    logic [SRAM_AW-1:0]    word_idx;
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic                  fire;

    assign word_idx = mem_addr[SRAM_AW-1:0];    // Upper bits alias.

    // The ack cycle itself is skipped, so a held request is not counted twice.
    assign fire = mem_access & ~mem_ack & (wait_cnt == WAIT_CNT_W'(WAIT_STATES));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wait-state counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
            mem_ack  <= 1'b0;
        end else begin
            mem_ack <= fire;
            if (fire | mem_ack | ~mem_access)
                wait_cnt <= '0;
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (fire) begin
            if (mem_wr_en) begin
                for (int b = 0; b < BSEL_W; b++) begin
                    if (mem_bytesel[b])
                        mem_array[word_idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                end
            end else begin
                mem_rdata <= mem_array[word_idx];   // Valid in the ack cycle.
            end
        end
    end

endmodule

// File: hdl/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem import mem_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic [ADDR_W-1:0] flush_addr,
    input  logic              pop,
    output logic [DATA_W-1:0] instr_word,
    output logic              instr_valid,
    // Data bus
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    input  logic              data_access,
    input  logic              data_wr_en,
    input  logic [BSEL_W-1:0] data_bytesel,
    output logic [DATA_W-1:0] data_rdata,
    output logic              data_ack
);

    logic [ADDR_W-1:0] instr_addr;
    logic              instr_access;
    logic [DATA_W-1:0] instr_rdata;
    logic              instr_ack;

    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic              mem_access;
    logic              mem_wr_en;
    logic [BSEL_W-1:0] mem_bytesel;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_ack;

    instr_prefetch u_prefetch (
        .clk, .reset,
        .flush, .flush_addr, .pop,
        .instr_word, .instr_valid,
        .instr_addr, .instr_access, .instr_rdata, .instr_ack
    );

    mem_arbiter u_arbiter (
        .clk, .reset,
        .instr_addr, .instr_access, .instr_rdata, .instr_ack,
        .data_addr, .data_wdata, .data_access, .data_wr_en, .data_bytesel,
        .data_rdata, .data_ack,
        .mem_addr, .mem_wdata, .mem_access, .mem_wr_en, .mem_bytesel,
        .mem_rdata, .mem_ack
    );

    sram_ctrl u_sram (
        .clk, .reset,
        .mem_addr, .mem_wdata, .mem_access, .mem_wr_en, .mem_bytesel,
        .mem_rdata, .mem_ack
    );

endmodule

// File: bench/mem_subsystem_assert.sv
`timescale 1ns/1ps

module mem_subsystem_assert import mem_pkg::*; (
    input logic              clk,
    input logic              reset,
    input logic              instr_access,
    input logic              instr_ack,
    input logic              data_access,
    input logic              data_ack,
    input logic              mem_access,
    input logic [ADDR_W-1:0] mem_addr,
    input logic              mem_ack
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Acknowledge routing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    acks_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(instr_ack && data_ack))
        else $error("instr_ack and data_ack are high in the same cycle");

    instr_ack_with_access: assert property (@(posedge clk) disable iff (reset)
        instr_ack |-> instr_access)
        else $error("instr_ack is high while instr_access is low");

    data_ack_with_access: assert property (@(posedge clk) disable iff (reset)
        data_ack |-> data_access)
        else $error("data_ack is high while data_access is low");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory bus hold
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_request_held: assert property (@(posedge clk) disable iff (reset)
        (mem_access && !mem_ack) |=> (mem_access && $stable(mem_addr)))
        else $error("mem_access dropped or mem_addr moved before mem_ack");

endmodule

// File: bench/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb import mem_pkg::*; ();

    localparam int ACCESS_TIMEOUT = 20;           // Cycles per memory access.
    localparam int SEED           = 32'h7327dde0;

    logic              clk;
    logic              reset;
    logic              flush;
    logic [ADDR_W-1:0] flush_addr;
    logic              pop;
    logic [DATA_W-1:0] instr_word;
    logic              instr_valid;
    logic [ADDR_W-1:0] data_addr;
    logic [DATA_W-1:0] data_wdata;
    logic              data_access;
    logic              data_wr_en;
    logic [BSEL_W-1:0] data_bytesel;
    logic [DATA_W-1:0] data_rdata;
    logic              data_ack;

    logic [DATA_W-1:0] model [SRAM_WORDS];        // Expected SRAM contents.

    mem_subsystem dut (
        .clk, .reset,
        .flush, .flush_addr, .pop,
        .instr_word, .instr_valid,
        .data_addr, .data_wdata, .data_access, .data_wr_en, .data_bytesel,
        .data_rdata, .data_ack
    );

    bind mem_arbiter mem_subsystem_assert u_bus_assert (
        .clk, .reset,
        .instr_access, .instr_ack, .data_access, .data_ack,
        .mem_access, .mem_addr, .mem_ack
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting and compares
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected)
            abort_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int model_index(input logic [ADDR_W-1:0] addr);
        return int'(addr) % SRAM_WORDS;           // Higher word bits alias.
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [BSEL_W-1:0] bsel);
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < BSEL_W; b++) begin
            if (bsel[b])
                merged[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return merged;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Cycles are counted from the first edge that sees data_access high.
    task automatic run_data_access(input logic wr, input logic [ADDR_W-1:0] addr,
                                   input logic [DATA_W-1:0] wdata,
                                   input logic [BSEL_W-1:0] bsel,
                                   output logic [DATA_W-1:0] rdata, output int cycles);
        @(posedge clk);
        data_addr    <= addr;
        data_wdata   <= wdata;
        data_wr_en   <= wr;
        data_bytesel <= bsel;
        data_access  <= 1'b1;
        cycles = 0;
        @(posedge clk);
        while (!data_ack) begin
            cycles++;
            if (cycles > ACCESS_TIMEOUT)
                abort_run("Timed out waiting for data_ack on the data port.");
            @(posedge clk);
        end
        rdata = data_rdata;
        data_access <= 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic [BSEL_W-1:0] bsel, output int cycles);
        logic [DATA_W-1:0] ignored;
        int                idx;
        idx = model_index(addr);
        run_data_access(1'b1, addr, wdata, bsel, ignored, cycles);
        model[idx] = merge_bytes(model[idx], wdata, bsel);
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr, output int cycles);
        logic [DATA_W-1:0] rdata;
        run_data_access(1'b0, addr, '0, {BSEL_W{1'b1}}, rdata, cycles);
        check_word("data_rdata", model[model_index(addr)], rdata);
    endtask

    // Traffic kept well away from the instruction window at stream_base.
    task automatic data_traffic(input logic [ADDR_W-1:0] stream_base, input int n_ops);
        logic [ADDR_W-1:0] addr;
        int                cycles;
        for (int i = 0; i < n_ops; i++) begin
            addr = stream_base + ADDR_W'(256) + ADDR_W'($urandom_range(255));
            if ($urandom_range(1) == 1)
                write_word(addr, DATA_W'($urandom), BSEL_W'($urandom), cycles);
            else
                read_word(addr, cycles);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic flush_to(input logic [ADDR_W-1:0] addr);
        @(posedge clk);
        flush      <= 1'b1;
        flush_addr <= addr;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic stream_check(input logic [ADDR_W-1:0] start, input int n_words);
        logic [ADDR_W-1:0] addr;
        int                taken;
        int                idle;
        addr  = start;
        taken = 0;
        idle  = 0;
        while (taken < n_words) begin
            @(posedge clk);
            if (pop) begin
                pop <= 1'b0;                      // Pop lands on this edge.
            end else if (instr_valid) begin
                check_word("instr_word", model[model_index(addr)], instr_word);
                pop <= 1'b1;
                addr = addr + 1'b1;
                taken++;
                idle = 0;
            end else begin
                idle++;
                if (idle > 2 * ACCESS_TIMEOUT)
                    abort_run("Timed out waiting for instr_valid from the prefetch queue.");
            end
        end
        @(posedge clk);
        pop <= 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int                cycles;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] alias_addr;
        logic [ADDR_W-1:0] other_addr;
        void'($urandom(SEED));
        reset        = 1'b1;
        flush        = 1'b0;
        flush_addr   = '0;
        pop          = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        data_access  = 1'b0;
        data_wr_en   = 1'b0;
        data_bytesel = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        @(posedge clk);
        check_bit("instr_valid", 1'b0, instr_valid);
        check_bit("data_ack", 1'b0, data_ack);

        for (int i = 0; i < SRAM_WORDS; i++)
            write_word(ADDR_W'(i), DATA_W'($urandom), {BSEL_W{1'b1}}, cycles);

        // Never popped since reset, so the queue is full and quiet.
        for (int i = 0; i < 40; i++) begin
            addr = ADDR_W'($urandom);
            write_word(addr, DATA_W'($urandom), BSEL_W'($urandom), cycles);
            check_cycles("data_ack write latency", WAIT_STATES + 1, cycles);
            read_word(addr, cycles);
            check_cycles("data_ack read latency", WAIT_STATES + 1, cycles);
        end

        addr = ADDR_W'($urandom);
        flush_to(addr);
        stream_check(addr, 24);

        addr = ADDR_W'($urandom);
        flush_to(addr);
        fork
            stream_check(addr, 32);
            data_traffic(addr, 24);
        join

        for (int i = 0; i < 4; i++) begin
            other_addr = ADDR_W'($urandom);
            addr       = ADDR_W'($urandom);
            flush_to(other_addr);
            flush_to(addr);                       // Lands while the first fetch is open.
            stream_check(addr, 8);
        end

        for (int i = 0; i < 8; i++) begin
            addr       = ADDR_W'($urandom);
            alias_addr = addr ^ {(ADDR_W - SRAM_AW)'($urandom) | 1'b1, {SRAM_AW{1'b0}}};
            write_word(addr, DATA_W'($urandom), {BSEL_W{1'b1}}, cycles);
            write_word(alias_addr, DATA_W'($urandom), BSEL_W'($urandom), cycles);
            read_word(addr, cycles);
            read_word(alias_addr, cycles);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: vlog.f
hdl/mem_pkg.sv
hdl/mem_arbiter.sv
hdl/instr_prefetch.sv
hdl/sram_ctrl.sv
hdl/mem_subsystem.sv
bench/mem_subsystem_assert.sv
bench/mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --assert --timing -f vlog.f \
    --top-module mem_subsystem_tb -Mdir "$BUILD_DIR" -o mem_subsystem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/mem_subsystem_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if grep -q "All checks passed" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
